/* Bender.yml */
package:
  name: noc_narrow_wide_router

sources:
  - rtl/noc_pkg.sv
  - rtl/noc_link_if.sv
  - rtl/noc_input_port.sv
  - rtl/noc_out_arbiter.sv
  - rtl/noc_crossbar.sv
  - rtl/noc_router.sv
  - rtl/noc_narrow_wide_router.sv
  - target: test
    files:
      - test/tb_noc_narrow_wide_router.sv

/* compile.f */
rtl/noc_pkg.sv
rtl/noc_link_if.sv
rtl/noc_input_port.sv
rtl/noc_out_arbiter.sv
rtl/noc_crossbar.sv
rtl/noc_router.sv
rtl/noc_narrow_wide_router.sv
test/tb_noc_narrow_wide_router.sv

/* rtl/noc_crossbar.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NoC crossbar
// Switches granted input links onto the outputs and steers
// ready back to the granted input
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_crossbar #(
  parameter int unsigned DataWidth = noc_pkg::NarrowWidth
) (
  noc_link_if.receiver                                    in_links [noc_pkg::NumPorts],
  input  logic [noc_pkg::NumPorts-1:0][noc_pkg::NumPorts-1:0] grant_i,
  output logic [noc_pkg::NumPorts-1:0]                    xfer_o,
  output logic [noc_pkg::NumPorts-1:0]                    last_o,
  noc_link_if.sender                                      out_links [noc_pkg::NumPorts]
);

  localparam int unsigned N  = noc_pkg::NumPorts;
  localparam int unsigned CW = noc_pkg::CoordWidth;

  logic [N-1:0]                in_valid, in_ready, in_last;
  logic [N-1:0][CW-1:0]        in_x, in_y;
  logic [N-1:0][DataWidth-1:0] in_data;

  logic [N-1:0]                out_valid, out_ready, out_last;
  logic [N-1:0][CW-1:0]        out_x, out_y;
  logic [N-1:0][DataWidth-1:0] out_data;

  // Interface arrays only take constant indices
  for (genvar p = 0; p < N; p++) begin : gen_links
    assign in_valid[p]        = in_links[p].valid;
    assign in_x[p]            = in_links[p].dst_x;
    assign in_y[p]            = in_links[p].dst_y;
    assign in_last[p]         = in_links[p].last;
    assign in_data[p]         = in_links[p].data;
    assign in_links[p].ready  = in_ready[p];

    assign out_links[p].valid = out_valid[p];
    assign out_links[p].dst_x = out_x[p];
    assign out_links[p].dst_y = out_y[p];
    assign out_links[p].last  = out_last[p];
    assign out_links[p].data  = out_data[p];
    assign out_ready[p]       = out_links[p].ready;
  end

  always_comb begin
    for (int unsigned o = 0; o < N; o++) begin
      out_valid[o] = 1'b0;
      out_x[o]     = '0;
      out_y[o]     = '0;
      out_last[o]  = 1'b0;
      out_data[o]  = '0;
      for (int unsigned i = 0; i < N; i++) begin
        if (grant_i[o][i]) begin
          out_valid[o] = in_valid[i];
          out_x[o]     = in_x[i];
          out_y[o]     = in_y[i];
          out_last[o]  = in_last[i];
          out_data[o]  = in_data[i];
        end
      end
    end
  end

  always_comb begin
    in_ready = '0;
    for (int unsigned o = 0; o < N; o++) begin
      for (int unsigned i = 0; i < N; i++) begin
        if (grant_i[o][i] && out_ready[o]) begin
          in_ready[i] = 1'b1;
        end
      end
    end
  end

  assign xfer_o = out_valid & out_ready;
  assign last_o = out_last;

endmodule

`default_nettype wire

/* rtl/noc_input_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NoC input port
// Circular flit FIFO with XY route computation for the
// flit at its head, presented as a one-hot request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_input_port #(
  parameter int unsigned DataWidth = noc_pkg::NarrowWidth,
  parameter int unsigned FifoDepth = noc_pkg::DefaultFifoDepth
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [noc_pkg::CoordWidth-1:0] my_x_i,
  input  logic [noc_pkg::CoordWidth-1:0] my_y_i,
  noc_link_if.receiver                   in_link,
  noc_link_if.sender                     out_link,
  output logic [noc_pkg::NumPorts-1:0]   route_o
);

  localparam int unsigned PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned CntWidth = $clog2(FifoDepth + 1);

  // Flit storage
  logic [DataWidth-1:0]           mem_data [FifoDepth];
  logic [noc_pkg::CoordWidth-1:0] mem_x    [FifoDepth];
  logic [noc_pkg::CoordWidth-1:0] mem_y    [FifoDepth];
  logic                           mem_last [FifoDepth];

  logic [PtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                full, empty, push, pop;

  noc_pkg::port_e route_dir;

  assign full  = (count_q == CntWidth'(FifoDepth));
  assign empty = (count_q == '0);
  assign push  = in_link.valid && in_link.ready;
  assign pop   = out_link.valid && out_link.ready;

  assign in_link.ready = !full;

  assign out_link.valid = !empty;
  assign out_link.dst_x = mem_x[rd_ptr_q];
  assign out_link.dst_y = mem_y[rd_ptr_q];
  assign out_link.last  = mem_last[rd_ptr_q];
  assign out_link.data  = mem_data[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_data[wr_ptr_q] <= in_link.data;
      mem_x[wr_ptr_q]    <= in_link.dst_x;
      mem_y[wr_ptr_q]    <= in_link.dst_y;
      mem_last[wr_ptr_q] <= in_link.last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(FifoDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // XY routing, x first and then y
  always_comb begin
    if (out_link.dst_x > my_x_i) begin
      route_dir = noc_pkg::PortEast;
    end else if (out_link.dst_x < my_x_i) begin
      route_dir = noc_pkg::PortWest;
    end else if (out_link.dst_y > my_y_i) begin
      route_dir = noc_pkg::PortNorth;
    end else if (out_link.dst_y < my_y_i) begin
      route_dir = noc_pkg::PortSouth;
    end else begin
      route_dir = noc_pkg::PortLocal;
    end
    route_o = '0;
    if (!empty) begin
      route_o[route_dir] = 1'b1;
    end
  end

endmodule

`default_nettype wire

/* rtl/noc_link_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NoC flit link
// One valid/ready channel carrying destination, last and data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

interface noc_link_if #(
  parameter int unsigned DataWidth = noc_pkg::NarrowWidth
);

  logic                            valid;
  logic                            ready;
  logic [noc_pkg::CoordWidth-1:0]  dst_x;
  logic [noc_pkg::CoordWidth-1:0]  dst_y;
  logic                            last;
  logic [DataWidth-1:0]            data;

  modport sender (
    output valid, dst_x, dst_y, last, data,
    input  ready
  );

  modport receiver (
    input  valid, dst_x, dst_y, last, data,
    output ready
  );

endinterface

`default_nettype wire

/* rtl/noc_narrow_wide_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Narrow and wide mesh router tile
// Two independent five-port routers on one tile coordinate,
// one for narrow flits and one for wide flits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_narrow_wide_router #(
  parameter int unsigned NarrowWidth = noc_pkg::NarrowWidth,
  parameter int unsigned WideWidth   = noc_pkg::WideWidth,
  parameter int unsigned FifoDepth   = noc_pkg::DefaultFifoDepth
) (
  input  logic                                               clk_i,
  input  logic                                               rst_i,
  input  logic [noc_pkg::CoordWidth-1:0]                     my_x_i,
  input  logic [noc_pkg::CoordWidth-1:0]                     my_y_i,

  // Narrow network
  input  logic [noc_pkg::NumPorts-1:0]                       narrow_valid_i,
  input  logic [noc_pkg::NumPorts-1:0][noc_pkg::CoordWidth-1:0] narrow_dst_x_i,
  input  logic [noc_pkg::NumPorts-1:0][noc_pkg::CoordWidth-1:0] narrow_dst_y_i,
  input  logic [noc_pkg::NumPorts-1:0]                       narrow_last_i,
  input  logic [noc_pkg::NumPorts-1:0][NarrowWidth-1:0]      narrow_data_i,
  input  logic [noc_pkg::NumPorts-1:0]                       narrow_ready_i,
  output logic [noc_pkg::NumPorts-1:0]                       narrow_ready_o,
  output logic [noc_pkg::NumPorts-1:0]                       narrow_valid_o,
  output logic [noc_pkg::NumPorts-1:0][noc_pkg::CoordWidth-1:0] narrow_dst_x_o,
  output logic [noc_pkg::NumPorts-1:0][noc_pkg::CoordWidth-1:0] narrow_dst_y_o,
  output logic [noc_pkg::NumPorts-1:0]                       narrow_last_o,
  output logic [noc_pkg::NumPorts-1:0][NarrowWidth-1:0]      narrow_data_o,

  // Wide network
  input  logic [noc_pkg::NumPorts-1:0]                       wide_valid_i,
  input  logic [noc_pkg::NumPorts-1:0][noc_pkg::CoordWidth-1:0] wide_dst_x_i,
  input  logic [noc_pkg::NumPorts-1:0][noc_pkg::CoordWidth-1:0] wide_dst_y_i,
  input  logic [noc_pkg::NumPorts-1:0]                       wide_last_i,
  input  logic [noc_pkg::NumPorts-1:0][WideWidth-1:0]        wide_data_i,
  input  logic [noc_pkg::NumPorts-1:0]                       wide_ready_i,
  output logic [noc_pkg::NumPorts-1:0]                       wide_ready_o,
  output logic [noc_pkg::NumPorts-1:0]                       wide_valid_o,
  output logic [noc_pkg::NumPorts-1:0][noc_pkg::CoordWidth-1:0] wide_dst_x_o,
  output logic [noc_pkg::NumPorts-1:0][noc_pkg::CoordWidth-1:0] wide_dst_y_o,
  output logic [noc_pkg::NumPorts-1:0]                       wide_last_o,
  output logic [noc_pkg::NumPorts-1:0][WideWidth-1:0]        wide_data_o
);

  noc_link_if #(.DataWidth(NarrowWidth)) narrow_in  [noc_pkg::NumPorts] ();
  noc_link_if #(.DataWidth(NarrowWidth)) narrow_out [noc_pkg::NumPorts] ();
  noc_link_if #(.DataWidth(WideWidth))   wide_in    [noc_pkg::NumPorts] ();
  noc_link_if #(.DataWidth(WideWidth))   wide_out   [noc_pkg::NumPorts] ();

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Plain ports to links
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  for (genvar p = 0; p < noc_pkg::NumPorts; p++) begin : gen_ports
    assign narrow_in[p].valid  = narrow_valid_i[p];
    assign narrow_in[p].dst_x  = narrow_dst_x_i[p];
    assign narrow_in[p].dst_y  = narrow_dst_y_i[p];
    assign narrow_in[p].last   = narrow_last_i[p];
    assign narrow_in[p].data   = narrow_data_i[p];
    assign narrow_ready_o[p]   = narrow_in[p].ready;
    assign narrow_valid_o[p]   = narrow_out[p].valid;
    assign narrow_dst_x_o[p]   = narrow_out[p].dst_x;
    assign narrow_dst_y_o[p]   = narrow_out[p].dst_y;
    assign narrow_last_o[p]    = narrow_out[p].last;
    assign narrow_data_o[p]    = narrow_out[p].data;
    assign narrow_out[p].ready = narrow_ready_i[p];

    assign wide_in[p].valid    = wide_valid_i[p];
    assign wide_in[p].dst_x    = wide_dst_x_i[p];
    assign wide_in[p].dst_y    = wide_dst_y_i[p];
    assign wide_in[p].last     = wide_last_i[p];
    assign wide_in[p].data     = wide_data_i[p];
    assign wide_ready_o[p]     = wide_in[p].ready;
    assign wide_valid_o[p]     = wide_out[p].valid;
    assign wide_dst_x_o[p]     = wide_out[p].dst_x;
    assign wide_dst_y_o[p]     = wide_out[p].dst_y;
    assign wide_last_o[p]      = wide_out[p].last;
    assign wide_data_o[p]      = wide_out[p].data;
    assign wide_out[p].ready   = wide_ready_i[p];
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Routers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  noc_router #(
    .DataWidth ( NarrowWidth ),
    .FifoDepth ( FifoDepth   )
  ) u_narrow_router (
    .clk_i     ( clk_i      ),
    .rst_i     ( rst_i      ),
    .my_x_i    ( my_x_i     ),
    .my_y_i    ( my_y_i     ),
    .in_links  ( narrow_in  ),
    .out_links ( narrow_out )
  );

  noc_router #(
    .DataWidth ( WideWidth ),
    .FifoDepth ( FifoDepth )
  ) u_wide_router (
    .clk_i     ( clk_i    ),
    .rst_i     ( rst_i    ),
    .my_x_i    ( my_x_i   ),
    .my_y_i    ( my_y_i   ),
    .in_links  ( wide_in  ),
    .out_links ( wide_out )
  );

endmodule

`default_nettype wire

/* rtl/noc_out_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NoC output arbiter
// Round-robin wormhole arbitration for one output port, the
// grant is held from the first flit up to the last flit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_out_arbiter (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic [noc_pkg::NumPorts-1:0] req_i,
  input  logic                         xfer_i,
  input  logic                         last_i,
  output logic [noc_pkg::NumPorts-1:0] grant_o
);

  localparam int unsigned IdxWidth = $clog2(noc_pkg::NumPorts);

  noc_pkg::arb_state_e state_q, state_d;

  logic [IdxWidth-1:0] rr_ptr_q;
  logic [IdxWidth-1:0] held_idx_q;
  logic [IdxWidth-1:0] win_idx;
  logic [IdxWidth-1:0] sel_idx;
  logic                found;
  logic                hold_q;
  logic                grant_any;

  // First requester at or after the round-robin pointer
  always_comb begin : pick_winner
    int unsigned idx;
    found   = 1'b0;
    win_idx = '0;
    for (int unsigned k = 0; k < noc_pkg::NumPorts; k++) begin
      idx = rr_ptr_q + k;
      if (idx >= noc_pkg::NumPorts) begin
        idx = idx - noc_pkg::NumPorts;
      end
      if (!found && req_i[idx]) begin
        found   = 1'b1;
        win_idx = IdxWidth'(idx);
      end
    end
  end

  // An offered grant sticks until its flit moves, so a stalled
  // output never switches inputs under a raised valid
  assign sel_idx   = (state_q == noc_pkg::ArbLocked || hold_q) ? held_idx_q : win_idx;
  assign grant_any = (state_q == noc_pkg::ArbLocked) || hold_q || found;

  always_comb begin
    grant_o = '0;
    if (grant_any) begin
      grant_o[sel_idx] = 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      noc_pkg::ArbIdle: begin
        if (xfer_i && !last_i) begin
          state_d = noc_pkg::ArbLocked;
        end
      end
      noc_pkg::ArbLocked: begin
        if (xfer_i && last_i) begin
          state_d = noc_pkg::ArbIdle;
        end
      end
      default: state_d = noc_pkg::ArbIdle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= noc_pkg::ArbIdle;
      rr_ptr_q   <= '0;
      held_idx_q <= '0;
      hold_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      hold_q  <= (state_q == noc_pkg::ArbIdle) && grant_any && !xfer_i;
      if (grant_any) begin
        held_idx_q <= sel_idx;
      end
      // Packet done, next search starts after the winner
      if (xfer_i && last_i) begin
        rr_ptr_q <= (sel_idx == IdxWidth'(noc_pkg::NumPorts - 1)) ? '0 : sel_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/noc_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Mesh NoC package
// Port directions, arbiter states, coordinate width and the
// default sizes shared by the narrow and wide routers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package noc_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Topology
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Five router ports, the encoding is also the port index
  typedef enum logic [2:0] {
    PortNorth = 3'd0,
    PortEast  = 3'd1,
    PortSouth = 3'd2,
    PortWest  = 3'd3,
    PortLocal = 3'd4
  } port_e;

  localparam int unsigned NumPorts = 5;

  // Two bits per axis gives a 4 by 4 mesh
  localparam int unsigned CoordWidth = 2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Default sizes
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam int unsigned NarrowWidth      = 32;
  localparam int unsigned WideWidth        = 128;
  localparam int unsigned DefaultFifoDepth = 2;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Output arbitration
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  // Locked holds the output for one input until its last flit
  typedef enum logic {
    ArbIdle   = 1'b0,
    ArbLocked = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

/* rtl/noc_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// NoC router
// Five-port XY mesh router, input FIFOs, one wormhole
// arbiter per output and a crossbar between them
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module noc_router #(
  parameter int unsigned DataWidth = noc_pkg::NarrowWidth,
  parameter int unsigned FifoDepth = noc_pkg::DefaultFifoDepth
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic [noc_pkg::CoordWidth-1:0] my_x_i,
  input  logic [noc_pkg::CoordWidth-1:0] my_y_i,
  noc_link_if.receiver                   in_links  [noc_pkg::NumPorts],
  noc_link_if.sender                     out_links [noc_pkg::NumPorts]
);

  localparam int unsigned N = noc_pkg::NumPorts;

  // Index order is [input][output] for route, [output][input] for req
  logic [N-1:0][N-1:0] route;
  logic [N-1:0][N-1:0] req;
  logic [N-1:0][N-1:0] grant;
  logic [N-1:0]        xfer;
  logic [N-1:0]        last;

  noc_link_if #(.DataWidth(DataWidth)) fifo_links [N] ();

  for (genvar i = 0; i < N; i++) begin : gen_inputs
    noc_input_port #(
      .DataWidth ( DataWidth ),
      .FifoDepth ( FifoDepth )
    ) u_input_port (
      .clk_i    ( clk_i         ),
      .rst_i    ( rst_i         ),
      .my_x_i   ( my_x_i        ),
      .my_y_i   ( my_y_i        ),
      .in_link  ( in_links[i]   ),
      .out_link ( fifo_links[i] ),
      .route_o  ( route[i]      )
    );
  end

  for (genvar o = 0; o < N; o++) begin : gen_outputs
    for (genvar i = 0; i < N; i++) begin : gen_req
      assign req[o][i] = route[i][o];
    end

    noc_out_arbiter u_out_arbiter (
      .clk_i   ( clk_i    ),
      .rst_i   ( rst_i    ),
      .req_i   ( req[o]   ),
      .xfer_i  ( xfer[o]  ),
      .last_i  ( last[o]  ),
      .grant_o ( grant[o] )
    );
  end

  noc_crossbar #(
    .DataWidth ( DataWidth )
  ) u_crossbar (
    .in_links  ( fifo_links ),
    .grant_i   ( grant      ),
    .xfer_o    ( xfer       ),
    .last_o    ( last       ),
    .out_links ( out_links  )
  );

endmodule

`default_nettype wire

/* test/noc_testdata.txt */
# columns: network (0 narrow, 1 wide), input port (0 N, 1 E, 2 S, 3 W, 4 L)
#          dst_x, dst_y, last, data in hex; the tile sits at 1,1
0 0 2 1 0 00001001
0 0 2 1 0 00001002
0 0 2 1 1 00001003
0 0 1 1 1 00001004
0 4 3 2 0 00004001
0 4 3 2 1 00004002
0 4 1 0 1 00004003
0 4 1 2 1 00004004
0 3 2 0 1 00003001
0 3 1 3 1 00003002
0 1 0 1 0 00002001
0 1 0 1 1 00002002
0 2 1 1 1 00005001
1 0 2 2 0 a000000000000000000000000000b001
1 0 2 2 1 a000000000000000000000000000b002
1 1 1 2 0 c0ffee00112233445566778899aa0001
1 1 1 2 1 c0ffee00112233445566778899aa0002
1 3 1 3 1 5a5a5a5a5a5a5a5a5a5a5a5a5a5a0001
1 3 2 3 1 7777777777777777777777777777000a
1 2 0 2 1 fedcba98765432100123456789ab0001
1 2 1 1 1 00000001000000020000000300000004
1 4 3 1 0 deadbeefcafef00d0000000000000001
1 4 3 1 1 deadbeefcafef00d0000000000000002

/* test/tb_noc_narrow_wide_router.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Narrow and wide router tile testbench
// Plays flit packets from the test data file into both
// networks and scores every output flit against XY routing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`default_nettype none

module tb_noc_narrow_wide_router;

  localparam int unsigned N          = noc_pkg::NumPorts;
  localparam int unsigned CW         = noc_pkg::CoordWidth;
  localparam int unsigned NW         = noc_pkg::NarrowWidth;
  localparam int unsigned WW         = noc_pkg::WideWidth;
  // Flit record is {last, dst_y, dst_x, data}
  localparam int unsigned FW         = 1 + 2 * CW + WW;
  localparam int unsigned MyX        = 1;
  localparam int unsigned MyY        = 1;
  localparam int unsigned HoldLimit  = 300;
  localparam int unsigned DrainLimit = 600;
  localparam int unsigned MaxStall   = 400;

  logic                   clk_i = 1'b0;
  logic                   rst_i;
  logic [CW-1:0]          my_x_i;
  logic [CW-1:0]          my_y_i;
  logic [N-1:0]           narrow_valid_i, narrow_last_i, narrow_ready_i;
  logic [N-1:0]           narrow_ready_o, narrow_valid_o, narrow_last_o;
  logic [N-1:0][CW-1:0]   narrow_dst_x_i, narrow_dst_y_i, narrow_dst_x_o, narrow_dst_y_o;
  logic [N-1:0][NW-1:0]   narrow_data_i, narrow_data_o;
  logic [N-1:0]           wide_valid_i, wide_last_i, wide_ready_i;
  logic [N-1:0]           wide_ready_o, wide_valid_o, wide_last_o;
  logic [N-1:0][CW-1:0]   wide_dst_x_i, wide_dst_y_i, wide_dst_x_o, wide_dst_y_o;
  logic [N-1:0][WW-1:0]   wide_data_i, wide_data_o;

  // Pending input flits per network and port, expected flits per input and output
  logic [FW-1:0] stim_q [2][N][$];
  logic [FW-1:0] exp_q  [2][N][N][$];
  logic [FW-1:0] prev_flit   [2][N];
  bit            prev_stall  [2][N];
  bit            owner_valid [2][N];
  int unsigned   owner       [2][N];
  int unsigned   stall_cnt   [2][N];
  bit            hold_wide;
  integer        seed;

  always #50 clk_i = ~clk_i;

  noc_narrow_wide_router u_noc_narrow_wide_router (
    .clk_i          ( clk_i          ),
    .rst_i          ( rst_i          ),
    .my_x_i         ( my_x_i         ),
    .my_y_i         ( my_y_i         ),
    .narrow_valid_i ( narrow_valid_i ),
    .narrow_dst_x_i ( narrow_dst_x_i ),
    .narrow_dst_y_i ( narrow_dst_y_i ),
    .narrow_last_i  ( narrow_last_i  ),
    .narrow_data_i  ( narrow_data_i  ),
    .narrow_ready_i ( narrow_ready_i ),
    .narrow_ready_o ( narrow_ready_o ),
    .narrow_valid_o ( narrow_valid_o ),
    .narrow_dst_x_o ( narrow_dst_x_o ),
    .narrow_dst_y_o ( narrow_dst_y_o ),
    .narrow_last_o  ( narrow_last_o  ),
    .narrow_data_o  ( narrow_data_o  ),
    .wide_valid_i   ( wide_valid_i   ),
    .wide_dst_x_i   ( wide_dst_x_i   ),
    .wide_dst_y_i   ( wide_dst_y_i   ),
    .wide_last_i    ( wide_last_i    ),
    .wide_data_i    ( wide_data_i    ),
    .wide_ready_i   ( wide_ready_i   ),
    .wide_ready_o   ( wide_ready_o   ),
    .wide_valid_o   ( wide_valid_o   ),
    .wide_dst_x_o   ( wide_dst_x_o   ),
    .wide_dst_y_o   ( wide_dst_y_o   ),
    .wide_last_o    ( wide_last_o    ),
    .wide_data_o    ( wide_data_o    )
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [FW-1:0] pack_flit(input logic last, input logic [CW-1:0] dx,
                                               input logic [CW-1:0] dy, input logic [WW-1:0] data);
    return {last, dy, dx, data};
  endfunction

  function automatic string net_name(input int n);
    return (n == 0) ? "narrow" : "wide";
  endfunction

  // Output port for a destination seen from tile 1,1
  function automatic int unsigned xy_route(input int dx, input int dy);
    if (dx > MyX) return 1;
    if (dx < MyX) return 3;
    if (dy > MyY) return 0;
    if (dy < MyY) return 2;
    return 4;
  endfunction

  function automatic bit net_drained(input int n);
    bit empty;
    empty = 1'b1;
    for (int i = 0; i < N; i++) begin
      if (stim_q[n][i].size() != 0) empty = 1'b0;
      for (int o = 0; o < N; o++) begin
        if (exp_q[n][i][o].size() != 0) empty = 1'b0;
      end
    end
    return empty;
  endfunction

  task automatic stop_on_error();
    $display("Testbench failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [FW-1:0] got,
                             input logic [FW-1:0] exp);
    assert (got === exp) else begin
      $display("Fail %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_flit(input int n, input int o, input logic [FW-1:0] got,
                            input logic [FW-1:0] exp);
    string pfx;
    pfx = net_name(n);
    check_value($sformatf("%s_data_o[%0d]", pfx, o), got[WW-1:0], exp[WW-1:0]);
    check_value($sformatf("%s_dst_x_o[%0d]", pfx, o), got[WW +: CW], exp[WW +: CW]);
    check_value($sformatf("%s_dst_y_o[%0d]", pfx, o), got[WW+CW +: CW], exp[WW+CW +: CW]);
    check_value($sformatf("%s_last_o[%0d]", pfx, o), got[FW-1], exp[FW-1]);
  endtask

  task automatic load_testdata();
    int            fd, rc, net, port, dx, dy, last, total;
    logic [WW-1:0] data;
    logic [FW-1:0] f;
    string         line;
    total = 0;
    fd = $fopen("test/noc_testdata.txt", "r");
    assert (fd != 0) else begin
      $display("Could not open the test data file");
      stop_on_error();
    end
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      if (rc > 1 && line.getc(0) != "#") begin
        rc = $sscanf(line, "%d %d %d %d %d %h", net, port, dx, dy, last, data);
        assert (rc == 6 && net >= 0 && net < 2 && port >= 0 && port < N) else begin
          $display("Malformed test data line: %s", line);
          stop_on_error();
        end
        if (net == 0) data[WW-1:NW] = '0;
        f = pack_flit(last[0], dx[CW-1:0], dy[CW-1:0], data);
        stim_q[net][port].push_back(f);
        exp_q[net][port][xy_route(dx, dy)].push_back(f);
        total++;
      end
    end
    $fclose(fd);
    assert (total > 0) else begin
      $display("The test data file holds no flits");
      stop_on_error();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Drive and score
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic drive_inputs();
    logic [FW-1:0] fn, fw;
    for (int p = 0; p < N; p++) begin
      fn = (stim_q[0][p].size() > 0) ? stim_q[0][p][0] : '0;
      fw = (stim_q[1][p].size() > 0) ? stim_q[1][p][0] : '0;
      narrow_valid_i[p] = (stim_q[0][p].size() > 0);
      narrow_dst_x_i[p] = fn[WW +: CW];
      narrow_dst_y_i[p] = fn[WW+CW +: CW];
      narrow_last_i[p]  = fn[FW-1];
      narrow_data_i[p]  = fn[NW-1:0];
      narrow_ready_i[p] = (($random(seed) & 3) != 0);
      wide_valid_i[p]   = (stim_q[1][p].size() > 0);
      wide_dst_x_i[p]   = fw[WW +: CW];
      wide_dst_y_i[p]   = fw[WW+CW +: CW];
      wide_last_i[p]    = fw[FW-1];
      wide_data_i[p]    = fw[WW-1:0];
      wide_ready_i[p]   = hold_wide ? 1'b0 : (($random(seed) & 3) != 0);
    end
  endtask

  task automatic track_input(input int n, input int p, input logic v, input logic r);
    if (v && r) begin
      stim_q[n][p].delete(0);
      stall_cnt[n][p] = 0;
    end else if (v) begin
      stall_cnt[n][p]++;
    end
    assert (stall_cnt[n][p] < MaxStall) else begin
      $display("Input %0d of the %s network waited too long for ready", p, net_name(n));
      stop_on_error();
    end
  endtask

  task automatic check_output(input int n, input int o, input logic v, input logic r,
                              input logic [FW-1:0] f);
    int unsigned   src;
    bit            found;
    logic [FW-1:0] head;
    // A stalled flit must stay on the output unchanged
    if (prev_stall[n][o]) begin
      check_value($sformatf("%s_valid_o[%0d]", net_name(n), o), v, 1'b1);
      check_flit(n, o, f, prev_flit[n][o]);
    end
    prev_stall[n][o] = v && !r;
    prev_flit[n][o]  = f;
    if (v && r) begin
      found = owner_valid[n][o];
      src   = owner[n][o];
      for (int i = 0; i < N; i++) begin
        if (!found && exp_q[n][i][o].size() > 0 && exp_q[n][i][o][0] === f) begin
          found = 1'b1;
          src   = i;
        end
      end
      assert (found && exp_q[n][src][o].size() > 0) else begin
        $display("Output %0d of the %s network delivered unexpected data 0x%0h",
                 o, net_name(n), f[WW-1:0]);
        stop_on_error();
      end
      head = exp_q[n][src][o].pop_front();
      check_flit(n, o, f, head);
      // Wormhole owner stays until the last flit
      owner_valid[n][o] = !f[FW-1];
      owner[n][o]       = src;
    end
  endtask

  task automatic sample_ports();
    for (int p = 0; p < N; p++) begin
      track_input(0, p, narrow_valid_i[p], narrow_ready_o[p]);
      track_input(1, p, wide_valid_i[p], wide_ready_o[p]);
      check_output(0, p, narrow_valid_o[p], narrow_ready_i[p],
                   pack_flit(narrow_last_o[p], narrow_dst_x_o[p], narrow_dst_y_o[p],
                             WW'(narrow_data_o[p])));
      check_output(1, p, wide_valid_o[p], wide_ready_i[p],
                   pack_flit(wide_last_o[p], wide_dst_x_o[p], wide_dst_y_o[p], wide_data_o[p]));
    end
  endtask

  task automatic run_until_drained(input int n, input int unsigned limit);
    int unsigned cycles;
    cycles = 0;
    while (!net_drained(n) && cycles < limit) begin
      @(negedge clk_i);
      drive_inputs();
      // Sample shortly before the rising edge
      #40;
      sample_ports();
      cycles++;
    end
    assert (net_drained(n)) else begin
      $display("The %s network did not drain within %0d cycles", net_name(n), limit);
      stop_on_error();
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    seed           = 32'h761;
    rst_i          = 1'b1;
    my_x_i         = CW'(MyX);
    my_y_i         = CW'(MyY);
    narrow_valid_i = '0;
    narrow_dst_x_i = '0;
    narrow_dst_y_i = '0;
    narrow_last_i  = '0;
    narrow_data_i  = '0;
    narrow_ready_i = '0;
    wide_valid_i   = '0;
    wide_dst_x_i   = '0;
    wide_dst_y_i   = '0;
    wide_last_i    = '0;
    wide_data_i    = '0;
    wide_ready_i   = '0;
    hold_wide      = 1'b1;
    load_testdata();
    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    for (int p = 0; p < N; p++) begin
      check_value($sformatf("narrow_valid_o[%0d]", p), narrow_valid_o[p], 1'b0);
      check_value($sformatf("wide_valid_o[%0d]", p), wide_valid_o[p], 1'b0);
      check_value($sformatf("narrow_ready_o[%0d]", p), narrow_ready_o[p], 1'b1);
      check_value($sformatf("wide_ready_o[%0d]", p), wide_ready_o[p], 1'b1);
    end
    // Narrow traffic must finish while the wide outputs stay blocked
    run_until_drained(0, HoldLimit);
    hold_wide = 1'b0;
    run_until_drained(1, DrainLimit);
    // No flit may remain on an output once all of them have arrived
    @(negedge clk_i);
    assert (narrow_valid_o == '0 && wide_valid_o == '0) else begin
      $display("An output still offered a flit after every expected flit arrived");
      stop_on_error();
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire
